// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f files.f --top-module tb_nic_wrapper \
		-Mdir obj_dir -o sim_nic_wrapper
	./obj_dir/sim_nic_wrapper > sim.log 2>&1; cat sim.log
	@grep -q "^TEST PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== files.f ====
hw/nic_reg_pkg.sv
hw/nic_bus_pkg.sv
hw/host_target.sv
hw/axil_skid.sv
hw/nic_regs.sv
hw/nic_wrapper.sv
testbench/tb_nic_wrapper.sv

// ==== hw/axil_skid.sv ====
`timescale 1ns/1ns

module axil_skid import nic_bus_pkg::*; (
	input  logic     CLK,
	input  logic     RST,
	input  axil_aw_t s_aw_i,
	input  logic     s_awvalid_i,
	output logic     s_awready_o,
	input  axil_w_t  s_w_i,
	input  logic     s_wvalid_i,
	output logic     s_wready_o,
	input  axil_ar_t s_ar_i,
	input  logic     s_arvalid_i,
	output logic     s_arready_o,
	output axil_b_t  s_b_o,
	output logic     s_bvalid_o,
	input  logic     s_bready_i,
	output axil_r_t  s_r_o,
	output logic     s_rvalid_o,
	input  logic     s_rready_i,
	output axil_aw_t m_aw_o,
	output logic     m_awvalid_o,
	input  logic     m_awready_i,
	output axil_w_t  m_w_o,
	output logic     m_wvalid_o,
	input  logic     m_wready_i,
	output axil_ar_t m_ar_o,
	output logic     m_arvalid_o,
	input  logic     m_arready_i,
	input  axil_b_t  m_b_i,
	input  logic     m_bvalid_i,
	output logic     m_bready_o,
	input  axil_r_t  m_r_i,
	input  logic     m_rvalid_i,
	output logic     m_rready_o
);

	logic [AXIL_CH-1:0][AXIL_PW-1:0] in_data;
	logic [AXIL_CH-1:0][AXIL_PW-1:0] out_data;
	logic [AXIL_CH-1:0]              in_valid;
	logic [AXIL_CH-1:0]              in_ready;
	logic [AXIL_CH-1:0]              out_valid;
	logic [AXIL_CH-1:0]              out_ready;

	// Channel order: AW, W, AR downstream, then B, R upstream
	assign in_data = {AXIL_PW'(m_r_i), AXIL_PW'(m_b_i), AXIL_PW'(s_ar_i),
		AXIL_PW'(s_w_i), AXIL_PW'(s_aw_i)};
	assign in_valid = {m_rvalid_i, m_bvalid_i, s_arvalid_i, s_wvalid_i, s_awvalid_i};
	assign out_ready = {s_rready_i, s_bready_i, m_arready_i, m_wready_i, m_awready_i};

	assign {m_rready_o, m_bready_o, s_arready_o, s_wready_o, s_awready_o} = in_ready;
	assign {s_rvalid_o, s_bvalid_o, m_arvalid_o, m_wvalid_o, m_awvalid_o} = out_valid;

	assign m_aw_o = out_data[0][$bits(axil_aw_t)-1:0];
	assign m_w_o = out_data[1][$bits(axil_w_t)-1:0];
	assign m_ar_o = out_data[2][$bits(axil_ar_t)-1:0];
	assign s_b_o = out_data[3][$bits(axil_b_t)-1:0];
	assign s_r_o = out_data[4][$bits(axil_r_t)-1:0];

	for (genvar c = 0; c < AXIL_CH; c++) begin : g_ch
		logic               main_vld;
		logic               skid_vld;
		logic [AXIL_PW-1:0] main_q;
		logic [AXIL_PW-1:0] skid_q;
		logic               push;
		logic               pop;

		// Ready only drops once the second entry is occupied
		assign in_ready[c] = !skid_vld;
		assign push = in_valid[c] && !skid_vld;
		assign pop = main_vld && out_ready[c];
		assign out_valid[c] = main_vld;
		assign out_data[c] = main_q;

		always_ff @(posedge CLK or posedge RST) begin
			if (RST) begin
				main_vld <= 1'b0;
				skid_vld <= 1'b0;
			end else if (skid_vld) begin
				if (pop)
					skid_vld <= 1'b0;
			end else if (push && main_vld && !pop) begin
				skid_vld <= 1'b1;
			end else begin
				main_vld <= push || (main_vld && !pop);
			end
		end

		always_ff @(posedge CLK) begin
			if (skid_vld) begin
				if (pop)
					main_q <= skid_q;
			end else if (push) begin
				if (main_vld && !pop)
					skid_q <= in_data[c];
				else
					main_q <= in_data[c];
			end
		end
	end

endmodule

// ==== hw/host_target.sv ====
`timescale 1ns/1ns

module host_target import nic_bus_pkg::*, nic_reg_pkg::*; (
	input  logic      CLK,
	input  logic      RST,
	input  host_req_t hst_req_i,
	output host_cpl_t hst_cpl_o,
	output axil_aw_t  aw_o,
	output logic      awvalid_o,
	input  logic      awready_i,
	output axil_w_t   w_o,
	output logic      wvalid_o,
	input  logic      wready_i,
	input  axil_b_t   b_i,
	input  logic      bvalid_i,
	output logic      bready_o,
	output axil_ar_t  ar_o,
	output logic      arvalid_o,
	input  logic      arready_i,
	input  axil_r_t   r_i,
	input  logic      rvalid_i,
	output logic      rready_o
);

	typedef enum logic [2:0] {
		IDLE,
		ISSUE,
		WAIT_RESP,
		DONE,
		ABORT
	} state_e;

	state_e state_q;
	logic   is_wr_q;
	logic   supported;
	logic   req_wr;
	logic   issue_done;

	// Classify by command and base hit
	always_comb begin
		supported = 1'b0;
		req_wr = 1'b0;
		case (hst_req_i.cmd)
			CMD_IO_READ, CMD_MEM_READ: supported = hst_req_i.base_hit;
			CMD_IO_WRITE, CMD_MEM_WRITE: begin
				supported = hst_req_i.base_hit;
				req_wr = 1'b1;
			end
			default: ;
		endcase
	end

	assign issue_done = (!awvalid_o || awready_i) && (!wvalid_o || wready_i) &&
		(!arvalid_o || arready_i);

	assign bready_o = (state_q == WAIT_RESP) && is_wr_q;
	assign rready_o = (state_q == WAIT_RESP) && !is_wr_q;

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			state_q <= IDLE;
			is_wr_q <= 1'b0;
			awvalid_o <= 1'b0;
			wvalid_o <= 1'b0;
			arvalid_o <= 1'b0;
			hst_cpl_o <= '0;
		end else begin
			hst_cpl_o.done <= 1'b0;
			case (state_q)
				IDLE: begin
					if (hst_req_i.valid) begin
						if (!supported) begin
							state_q <= ABORT;
						end else begin
							is_wr_q <= req_wr;
							awvalid_o <= req_wr;
							wvalid_o <= req_wr;
							arvalid_o <= !req_wr;
							state_q <= ISSUE;
						end
					end
				end
				ISSUE: begin
					// AW and W may be accepted on different edges
					if (awready_i)
						awvalid_o <= 1'b0;
					if (wready_i)
						wvalid_o <= 1'b0;
					if (arready_i)
						arvalid_o <= 1'b0;
					if (issue_done)
						state_q <= WAIT_RESP;
				end
				WAIT_RESP: begin
					if (is_wr_q && bvalid_i) begin
						hst_cpl_o <= '{done: 1'b1, abort: 1'b0,
							error: (b_i.resp != RESP_OKAY), rdata: 32'h0};
						state_q <= DONE;
					end else if (!is_wr_q && rvalid_i) begin
						hst_cpl_o <= '{done: 1'b1, abort: 1'b0,
							error: (r_i.resp != RESP_OKAY), rdata: r_i.data};
						state_q <= DONE;
					end
				end
				ABORT: begin
					hst_cpl_o <= '{done: 1'b1, abort: 1'b1, error: 1'b0, rdata: 32'h0};
					state_q <= DONE;
				end
				DONE: begin
					// Wait for the host to drop its request
					if (!hst_req_i.valid)
						state_q <= IDLE;
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// Payload held stable for the whole transaction
	always_ff @(posedge CLK) begin
		if (state_q == IDLE && hst_req_i.valid) begin
			aw_o.addr <= hst_req_i.addr[REG_AW-1:0];
			ar_o.addr <= hst_req_i.addr[REG_AW-1:0];
			w_o.data <= hst_req_i.data;
			w_o.strb <= hst_req_i.be;
		end
	end

endmodule

// ==== hw/nic_bus_pkg.sv ====
package nic_bus_pkg;

	import nic_reg_pkg::host_cmd_e;

	// Register window offset width
	localparam int REG_AW = 8;

	localparam int AXIL_DW = 32;
	localparam int AXIL_SW = AXIL_DW / 8;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axil_resp_e;

	typedef struct packed {
		logic [REG_AW-1:0] addr;
	} axil_aw_t;

	typedef struct packed {
		logic [AXIL_DW-1:0] data;
		logic [AXIL_SW-1:0] strb;
	} axil_w_t;

	typedef struct packed {
		axil_resp_e resp;
	} axil_b_t;

	typedef struct packed {
		logic [REG_AW-1:0] addr;
	} axil_ar_t;

	typedef struct packed {
		logic [AXIL_DW-1:0] data;
		axil_resp_e         resp;
	} axil_r_t;

	// Skid stage channel count and widest payload (W)
	localparam int AXIL_CH = 5;
	localparam int AXIL_PW = $bits(axil_w_t);

	typedef struct packed {
		logic        valid;
		logic        base_hit;
		host_cmd_e   cmd;
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0]  be;
	} host_req_t;

	typedef struct packed {
		logic        done;
		logic        abort;
		logic        error;
		logic [31:0] rdata;
	} host_cpl_t;

endpackage

// ==== hw/nic_reg_pkg.sv ====
package nic_reg_pkg;

	// PCI bus command codes
	typedef enum logic [3:0] {
		CMD_IO_READ   = 4'b0010,
		CMD_IO_WRITE  = 4'b0011,
		CMD_MEM_READ  = 4'b0110,
		CMD_MEM_WRITE = 4'b0111,
		CMD_CFG_READ  = 4'b1010,
		CMD_CFG_WRITE = 4'b1011
	} host_cmd_e;

	// Register offsets
	localparam logic [7:0] REG_CTRL    = 8'h00;
	localparam logic [7:0] REG_STATUS  = 8'h08;
	localparam logic [7:0] REG_SCRATCH = 8'h10;
	localparam logic [7:0] REG_ICR     = 8'hC0;
	localparam logic [7:0] REG_ICS     = 8'hC8;
	localparam logic [7:0] REG_IMS     = 8'hD0;
	localparam logic [7:0] REG_IMC     = 8'hD8;

	// Software reset in CTRL, self clearing
	localparam int CTRL_RST_BIT = 26;

	localparam int STATUS_LU_BIT = 1;

	// Interrupt cause bits in ICR/ICS/IMS/IMC
	localparam int CAUSE_W = 16;

	localparam logic [31:0]        CTRL_RESET    = 32'h0000_0000;
	localparam logic [31:0]        SCRATCH_RESET = 32'h0000_0000;
	localparam logic [CAUSE_W-1:0] ICR_RESET     = '0;
	localparam logic [CAUSE_W-1:0] IMS_RESET     = '0;

endpackage

// ==== hw/nic_regs.sv ====
`timescale 1ns/1ns

module nic_regs import nic_bus_pkg::*, nic_reg_pkg::*; (
	input  logic               CLK,
	input  logic               RST,
	input  axil_aw_t           aw_i,
	input  logic               awvalid_i,
	output logic               awready_o,
	input  axil_w_t            w_i,
	input  logic               wvalid_i,
	output logic               wready_o,
	output axil_b_t            b_o,
	output logic               bvalid_o,
	input  logic               bready_i,
	input  axil_ar_t           ar_i,
	input  logic               arvalid_i,
	output logic               arready_o,
	output axil_r_t            r_o,
	output logic               rvalid_o,
	input  logic               rready_i,
	input  logic               link_up_i,
	input  logic [CAUSE_W-1:0] cause_evt_i,
	output logic               int_n_o
);

	logic [31:0]        ctrl_q;
	logic [31:0]        scratch_q;
	logic [CAUSE_W-1:0] icr_q;
	logic [CAUSE_W-1:0] ims_q;
	logic               sw_rst_q;
	logic               wr_en;
	logic               rd_en;
	logic [31:0]        wmask;
	logic [31:0]        wdata_m;
	logic [31:0]        ctrl_wr;
	logic [31:0]        status_rd;
	logic [31:0]        rdata;
	logic [CAUSE_W-1:0] icr_d;
	logic [CAUSE_W-1:0] ims_d;
	axil_resp_e         wresp;

	// AW and W taken together, never while a B is outstanding
	assign wr_en = awvalid_i && wvalid_i && !bvalid_o;
	assign awready_o = wvalid_i && !bvalid_o;
	assign wready_o = awvalid_i && !bvalid_o;
	assign rd_en = arvalid_i && !rvalid_o;
	assign arready_o = !rvalid_o;

	always_comb begin
		for (int i = 0; i < AXIL_SW; i++)
			wmask[8*i +: 8] = {8{w_i.strb[i]}};
	end

	assign wdata_m = w_i.data & wmask;
	assign ctrl_wr = (ctrl_q & ~wmask) | wdata_m;

	always_comb begin
		status_rd = '0;
		status_rd[STATUS_LU_BIT] = link_up_i;
	end

	// Read-only registers
	assign wresp = (aw_i.addr == REG_STATUS || aw_i.addr == REG_ICR) ?
		RESP_SLVERR : RESP_OKAY;

	always_comb begin
		case (ar_i.addr)
			REG_CTRL:    rdata = ctrl_q;
			REG_STATUS:  rdata = status_rd;
			REG_SCRATCH: rdata = scratch_q;
			REG_ICR:     rdata = 32'(icr_q);
			REG_IMS:     rdata = 32'(ims_q);
			default:     rdata = '0;
		endcase
	end

	always_comb begin
		icr_d = icr_q;
		ims_d = ims_q;
		if (sw_rst_q) begin
			icr_d = ICR_RESET;
			ims_d = IMS_RESET;
		end else begin
			if (rd_en && ar_i.addr == REG_ICR)
				icr_d = '0;
			if (wr_en) begin
				case (aw_i.addr)
					REG_ICS: icr_d = icr_d | wdata_m[CAUSE_W-1:0];
					REG_IMS: ims_d = ims_q | wdata_m[CAUSE_W-1:0];
					REG_IMC: ims_d = ims_q & ~wdata_m[CAUSE_W-1:0];
					default: ;
				endcase
			end
		end
		// New events are never lost to a clear
		icr_d = icr_d | cause_evt_i;
	end

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			ctrl_q <= CTRL_RESET;
			scratch_q <= SCRATCH_RESET;
			icr_q <= ICR_RESET;
			ims_q <= IMS_RESET;
			sw_rst_q <= 1'b0;
			int_n_o <= 1'b1;
		end else begin
			icr_q <= icr_d;
			ims_q <= ims_d;
			int_n_o <= !(|(icr_q & ims_q));
			sw_rst_q <= 1'b0;
			if (sw_rst_q) begin
				ctrl_q <= CTRL_RESET;
				scratch_q <= SCRATCH_RESET;
			end else if (wr_en) begin
				case (aw_i.addr)
					REG_CTRL: begin
						ctrl_q <= ctrl_wr & ~(32'd1 << CTRL_RST_BIT);
						sw_rst_q <= ctrl_wr[CTRL_RST_BIT];
					end
					REG_SCRATCH: scratch_q <= (scratch_q & ~wmask) | wdata_m;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			bvalid_o <= 1'b0;
			rvalid_o <= 1'b0;
		end else begin
			if (wr_en)
				bvalid_o <= 1'b1;
			else if (bready_i)
				bvalid_o <= 1'b0;
			if (rd_en)
				rvalid_o <= 1'b1;
			else if (rready_i)
				rvalid_o <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (wr_en)
			b_o.resp <= wresp;
		if (rd_en) begin
			r_o.data <= rdata;
			r_o.resp <= RESP_OKAY;
		end
	end

endmodule

// ==== hw/nic_wrapper.sv ====
`timescale 1ns/1ns

module nic_wrapper import nic_bus_pkg::*, nic_reg_pkg::*; (
	input  logic               CLK,
	input  logic               RST,
	input  host_req_t          hst_req_i,
	output host_cpl_t          hst_cpl_o,
	input  logic               link_up_i,
	input  logic [CAUSE_W-1:0] cause_evt_i,
	output logic               int_n_o
);

	// Target side of the skid stage
	axil_aw_t t_aw;
	axil_w_t  t_w;
	axil_b_t  t_b;
	axil_ar_t t_ar;
	axil_r_t  t_r;
	logic     t_awvalid, t_awready, t_wvalid, t_wready, t_bvalid, t_bready;
	logic     t_arvalid, t_arready, t_rvalid, t_rready;

	// Register block side
	axil_aw_t r_aw;
	axil_w_t  r_w;
	axil_b_t  r_b;
	axil_ar_t r_ar;
	axil_r_t  r_r;
	logic     r_awvalid, r_awready, r_wvalid, r_wready, r_bvalid, r_bready;
	logic     r_arvalid, r_arready, r_rvalid, r_rready;

	host_target u_target (
		.CLK(CLK), .RST(RST),
		.hst_req_i(hst_req_i), .hst_cpl_o(hst_cpl_o),
		.aw_o(t_aw), .awvalid_o(t_awvalid), .awready_i(t_awready),
		.w_o(t_w), .wvalid_o(t_wvalid), .wready_i(t_wready),
		.b_i(t_b), .bvalid_i(t_bvalid), .bready_o(t_bready),
		.ar_o(t_ar), .arvalid_o(t_arvalid), .arready_i(t_arready),
		.r_i(t_r), .rvalid_i(t_rvalid), .rready_o(t_rready)
	);

	axil_skid u_skid (
		.CLK(CLK), .RST(RST),
		.s_aw_i(t_aw), .s_awvalid_i(t_awvalid), .s_awready_o(t_awready),
		.s_w_i(t_w), .s_wvalid_i(t_wvalid), .s_wready_o(t_wready),
		.s_ar_i(t_ar), .s_arvalid_i(t_arvalid), .s_arready_o(t_arready),
		.s_b_o(t_b), .s_bvalid_o(t_bvalid), .s_bready_i(t_bready),
		.s_r_o(t_r), .s_rvalid_o(t_rvalid), .s_rready_i(t_rready),
		.m_aw_o(r_aw), .m_awvalid_o(r_awvalid), .m_awready_i(r_awready),
		.m_w_o(r_w), .m_wvalid_o(r_wvalid), .m_wready_i(r_wready),
		.m_ar_o(r_ar), .m_arvalid_o(r_arvalid), .m_arready_i(r_arready),
		.m_b_i(r_b), .m_bvalid_i(r_bvalid), .m_bready_o(r_bready),
		.m_r_i(r_r), .m_rvalid_i(r_rvalid), .m_rready_o(r_rready)
	);

	nic_regs u_regs (
		.CLK(CLK), .RST(RST),
		.aw_i(r_aw), .awvalid_i(r_awvalid), .awready_o(r_awready),
		.w_i(r_w), .wvalid_i(r_wvalid), .wready_o(r_wready),
		.b_o(r_b), .bvalid_o(r_bvalid), .bready_i(r_bready),
		.ar_i(r_ar), .arvalid_i(r_arvalid), .arready_o(r_arready),
		.r_o(r_r), .rvalid_o(r_rvalid), .rready_i(r_rready),
		.link_up_i(link_up_i), .cause_evt_i(cause_evt_i), .int_n_o(int_n_o)
	);

endmodule

// ==== testbench/tb_nic_wrapper.sv ====
`timescale 1ns/1ns

module tb_nic_wrapper import nic_bus_pkg::*, nic_reg_pkg::*; ();

	localparam logic [23:0] BAR_BASE = 24'hFEB000;

	typedef struct packed {
		host_req_t          req;
		logic [CAUSE_W-1:0] evt;
		logic               link;
		host_cpl_t          exp_cpl;
		logic               exp_irq_n;
	} row_t;

	logic               CLK;
	logic               RST;
	host_req_t          hst_req;
	host_cpl_t          hst_cpl;
	logic               link_up;
	logic [CAUSE_W-1:0] cause_evt;
	logic               int_n;

	row_t        rows[$];
	string       row_names[$];
	logic [31:0] rng_state;
	int          mismatch_count;
	int          missing_count;

	nic_wrapper u_nic_wrapper (
		.CLK(CLK),
		.RST(RST),
		.hst_req_i(hst_req),
		.hst_cpl_o(hst_cpl),
		.link_up_i(link_up),
		.cause_evt_i(cause_evt),
		.int_n_o(int_n)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	// Numerical Recipes LCG
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Byte lanes with a set enable take the new data
	function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
		input logic [31:0] new_val, input logic [3:0] be);
		logic [31:0] res;
		res = old_val;
		for (int i = 0; i < 4; i++) begin
			if (be[i])
				res[8*i +: 8] = new_val[8*i +: 8];
		end
		return res;
	endfunction

	function automatic string format_cpl(input host_cpl_t c);
		return $sformatf("done=%b abort=%b error=%b rdata=%h",
			c.done, c.abort, c.error, c.rdata);
	endfunction

	task automatic check_cpl(input string name, input host_cpl_t exp, input host_cpl_t act);
		if (exp !== act) begin
			$display("MISMATCH %s: expected %s actual %s",
				name, format_cpl(exp), format_cpl(act));
			mismatch_count++;
		end
	endtask

	task automatic check_resp(input string name, input axil_resp_e exp, input axil_resp_e act);
		if (exp !== act) begin
			$display("MISMATCH %s: expected resp %s actual resp %s",
				name, exp.name(), act.name());
			mismatch_count++;
		end
	endtask

	task automatic check_irq(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("MISMATCH %s: expected int_n %b actual int_n %b", name, exp, act);
			mismatch_count++;
		end
	endtask

	task automatic push_row(input string name, input host_req_t req,
		input logic [CAUSE_W-1:0] evt, input logic link, input host_cpl_t exp,
		input logic irq_n);
		row_t r;
		r.req = req;
		r.evt = evt;
		r.link = link;
		r.exp_cpl = exp;
		r.exp_irq_n = irq_n;
		rows.push_back(r);
		row_names.push_back(name);
	endtask

	task automatic add_wr(input string name, input host_cmd_e cmd, input logic hit,
		input logic [7:0] offs, input logic [31:0] data, input logic [3:0] be,
		input logic abort, input logic err, input logic irq_n);
		host_req_t req;
		host_cpl_t exp;
		req = '{valid: 1'b1, base_hit: hit, cmd: cmd, addr: {BAR_BASE, offs},
			data: data, be: be};
		exp = '{done: 1'b1, abort: abort, error: err, rdata: 32'h0};
		push_row(name, req, '0, 1'b0, exp, irq_n);
	endtask

	task automatic add_rd(input string name, input host_cmd_e cmd, input logic hit,
		input logic [7:0] offs, input logic [CAUSE_W-1:0] evt, input logic link,
		input logic abort, input logic [31:0] rdata, input logic irq_n);
		host_req_t req;
		host_cpl_t exp;
		req = '{valid: 1'b1, base_hit: hit, cmd: cmd, addr: {BAR_BASE, offs},
			data: 32'h0, be: 4'hF};
		exp = '{done: 1'b1, abort: abort, error: 1'b0, rdata: rdata};
		push_row(name, req, evt, link, exp, irq_n);
	endtask

	// Request held until done, events pulsed for one cycle
	task automatic apply_row(input int i);
		row_t      r;
		host_cpl_t got;
		logic      seen;
		r = rows[i];
		seen = 1'b0;
		got = '0;
		@(posedge CLK);
		#1;
		link_up = r.link;
		cause_evt = r.evt;
		hst_req = r.req;
		@(posedge CLK);
		#1;
		cause_evt = '0;
		for (int n = 0; n < 32 && !seen; n++) begin
			@(negedge CLK);
			if (hst_cpl.done) begin
				seen = 1'b1;
				got = hst_cpl;
			end
		end
		if (!seen) begin
			$display("No completion seen for %s within 32 cycles", row_names[i]);
			missing_count++;
		end
		@(posedge CLK);
		#1;
		hst_req = '0;
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		if (seen) begin
			check_cpl(row_names[i], r.exp_cpl, got);
			check_resp(row_names[i], r.exp_cpl.error ? RESP_SLVERR : RESP_OKAY,
				got.error ? RESP_SLVERR : RESP_OKAY);
		end
		check_irq(row_names[i], r.exp_irq_n, int_n);
	endtask

	task automatic build_table();
		logic [31:0] d1;
		logic [31:0] d2;
		logic [3:0]  s1;
		logic [3:0]  s2;
		logic [31:0] merged;
		rng_state = 32'h637c94d3;
		rng_state = lcg_next(rng_state);
		d1 = rng_state;
		rng_state = lcg_next(rng_state);
		s1 = rng_state[31:28];
		rng_state = lcg_next(rng_state);
		d2 = rng_state;
		rng_state = lcg_next(rng_state);
		s2 = rng_state[31:28];
		merged = merge_bytes(merge_bytes(32'h0, d1, s1), d2, s2);

		add_wr("scratch_wr1", CMD_MEM_WRITE, 1'b1, REG_SCRATCH, d1, s1, 1'b0, 1'b0, 1'b1);
		add_wr("scratch_wr2", CMD_MEM_WRITE, 1'b1, REG_SCRATCH, d2, s2, 1'b0, 1'b0, 1'b1);
		add_rd("scratch_rd", CMD_MEM_READ, 1'b1, REG_SCRATCH, '0, 1'b0, 1'b0, merged, 1'b1);
		add_wr("nohit_wr", CMD_MEM_WRITE, 1'b0, REG_SCRATCH, 32'hDEADBEEF, 4'hF,
			1'b1, 1'b0, 1'b1);
		add_wr("cfg_wr", CMD_CFG_WRITE, 1'b1, REG_SCRATCH, 32'h1234_5678, 4'hF,
			1'b1, 1'b0, 1'b1);
		add_rd("cfg_rd", CMD_CFG_READ, 1'b1, REG_SCRATCH, '0, 1'b0, 1'b1, 32'h0, 1'b1);
		add_rd("scratch_rd_kept", CMD_MEM_READ, 1'b1, REG_SCRATCH, '0, 1'b0, 1'b0,
			merged, 1'b1);
		add_wr("status_wr", CMD_MEM_WRITE, 1'b1, REG_STATUS, 32'hFFFF_FFFF, 4'hF,
			1'b0, 1'b1, 1'b1);
		add_wr("icr_wr", CMD_MEM_WRITE, 1'b1, REG_ICR, 32'h0000_FFFF, 4'hF, 1'b0, 1'b1, 1'b1);
		add_rd("status_link_up", CMD_MEM_READ, 1'b1, REG_STATUS, '0, 1'b1, 1'b0,
			32'h1 << STATUS_LU_BIT, 1'b1);
		add_rd("status_link_down", CMD_MEM_READ, 1'b1, REG_STATUS, '0, 1'b0, 1'b0,
			32'h0, 1'b1);
		add_wr("ics_set", CMD_MEM_WRITE, 1'b1, REG_ICS, 32'h0000_0003, 4'hF, 1'b0, 1'b0, 1'b1);
		add_wr("ims_set", CMD_MEM_WRITE, 1'b1, REG_IMS, 32'h0000_0001, 4'hF, 1'b0, 1'b0, 1'b0);
		add_wr("imc_clr", CMD_MEM_WRITE, 1'b1, REG_IMC, 32'h0000_0001, 4'hF, 1'b0, 1'b0, 1'b1);
		add_rd("icr_rd", CMD_MEM_READ, 1'b1, REG_ICR, '0, 1'b0, 1'b0, 32'h3, 1'b1);
		add_rd("icr_rd_empty", CMD_MEM_READ, 1'b1, REG_ICR, '0, 1'b0, 1'b0, 32'h0, 1'b1);
		add_rd("evt_pulse", CMD_MEM_READ, 1'b1, REG_IMS, 16'h0005, 1'b0, 1'b0, 32'h0, 1'b1);
		add_wr("ims_unmask_evt", CMD_MEM_WRITE, 1'b1, REG_IMS, 32'h0000_0004, 4'hF,
			1'b0, 1'b0, 1'b0);
		add_wr("scratch_fill", CMD_MEM_WRITE, 1'b1, REG_SCRATCH, 32'hA5A5_5A5A, 4'hF,
			1'b0, 1'b0, 1'b0);
		add_wr("ctrl_wr", CMD_MEM_WRITE, 1'b1, REG_CTRL, 32'h0000_0041, 4'hF, 1'b0, 1'b0, 1'b0);
		add_rd("ctrl_rd", CMD_MEM_READ, 1'b1, REG_CTRL, '0, 1'b0, 1'b0, 32'h41, 1'b0);
		add_wr("ctrl_swrst", CMD_MEM_WRITE, 1'b1, REG_CTRL,
			32'h0000_0041 | (32'h1 << CTRL_RST_BIT), 4'hF, 1'b0, 1'b0, 1'b1);
		add_rd("ctrl_rd_rst", CMD_MEM_READ, 1'b1, REG_CTRL, '0, 1'b0, 1'b0, 32'h0, 1'b1);
		add_rd("scratch_rd_rst", CMD_MEM_READ, 1'b1, REG_SCRATCH, '0, 1'b0, 1'b0, 32'h0, 1'b1);
		add_rd("ims_rd_rst", CMD_MEM_READ, 1'b1, REG_IMS, '0, 1'b0, 1'b0, 32'h0, 1'b1);
		add_rd("icr_rd_rst", CMD_MEM_READ, 1'b1, REG_ICR, '0, 1'b0, 1'b0, 32'h0, 1'b1);
		add_rd("io_rd_unmapped", CMD_IO_READ, 1'b1, 8'h40, '0, 1'b0, 1'b0, 32'h0, 1'b1);
		add_wr("io_wr_unmapped", CMD_IO_WRITE, 1'b1, 8'h44, 32'hCAFE_F00D, 4'hF,
			1'b0, 1'b0, 1'b1);
		add_rd("io_rd_unmapped2", CMD_IO_READ, 1'b1, 8'h44, '0, 1'b0, 1'b0, 32'h0, 1'b1);
	endtask

	// Watchdog sized from the table, armed at reset release
	initial begin
		@(negedge RST);
		repeat (rows.size() * 64) @(posedge CLK);
		$display("Watchdog expired after %0d cycles, run did not finish", rows.size() * 64);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		RST = 1'b1;
		hst_req = '0;
		link_up = 1'b0;
		cause_evt = '0;
		mismatch_count = 0;
		missing_count = 0;
		build_table();
		repeat (5) @(posedge CLK);
		#1;
		RST = 1'b0;
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		check_cpl("after_reset", '0, hst_cpl);
		check_irq("after_reset", 1'b1, int_n);
		for (int i = 0; i < rows.size(); i++)
			apply_row(i);
		$display("Checks done: %0d mismatches, %0d missing completions",
			mismatch_count, missing_count);
		if (mismatch_count == 0 && missing_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
